// ==== build.f ====
+incdir+logic
logic/noc_flit_pkg.sv
logic/noc_port_pkg.sv
logic/input_port.sv
logic/output_arbiter.sv
logic/output_port.sv
logic/mesh_router.sv
bench/router_clock.sv
bench/router_assert.sv
bench/router_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= router_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/router_tb.sv ====
`include "noc_cfg.svh"

module router_tb import noc_flit_pkg::*, noc_port_pkg::*; ();

  localparam int N           = `NOC_PORT_COUNT;
  localparam int NUM_WORMS   = 60;
  localparam int CYCLE_LIMIT = NUM_WORMS * 4 * 20;
  localparam int DRIVE_DELAY = 10;
  localparam int POS_X       = 2;
  localparam int POS_Y       = 2;

  logic          clk;
  logic          rst;
  xy_t           position;
  flit_t [N-1:0] data_i;
  logic  [N-1:0] void_i;
  logic  [N-1:0] stop_o;
  flit_t [N-1:0] data_o;
  logic  [N-1:0] void_o;
  logic  [N-1:0] stop_i;

  // Flits still to be sent by each input
  flit_t send_q [N][$];
  // Output of the worm each input is sending
  int    cur_out [N];
  // Expected flits per input and output pair at index input*N+output
  flit_t exp_q [N*N][$];
  // Input that owns each output until its tail or -1 when free
  int    lock_src [N];
  logic  [N-1:0] prev_stop;
  logic  [N-1:0] prev_void;
  flit_t prev_data [N];
  int    cycles;
  int    worms_made;
  int    seq;

  router_clock u_clock (
    .clk_o(clk),
    .rst_o(rst)
  );

  mesh_router mesh_router_inst (
    .clk,
    .rst,
    .position_i(position),
    .data_i,
    .void_i,
    .stop_o,
    .data_o,
    .void_o,
    .stop_i
  );

  ////////////////////
  // Reference model
  ////////////////////

  // XY order with x first then y
  function automatic int toward(input int px, input int py, input int dx, input int dy);
    if (dx < px) return int'(PORT_WEST);
    if (dx > px) return int'(PORT_EAST);
    if (dy < py) return int'(PORT_NORTH);
    if (dy > py) return int'(PORT_SOUTH);
    return int'(PORT_LOCAL);
  endfunction

  // Route the neighbour behind output out will use
  function automatic route_t next_hop(input int out, input header_t h);
    int px;
    int py;
    px = POS_X;
    py = POS_Y;
    if (out == PORT_NORTH) py = py - 1;
    if (out == PORT_SOUTH) py = py + 1;
    if (out == PORT_WEST)  px = px - 1;
    if (out == PORT_EAST)  px = px + 1;
    return route_t'(1) << toward(px, py, int'(h.destination.x), int'(h.destination.y));
  endfunction

  function automatic int port_of(input route_t r);
    int idx;
    idx = 0;
    for (int k = 0; k < N; k++) begin
      if (r[k]) idx = k;
    end
    return idx;
  endfunction

  function automatic int pending();
    int total;
    total = 0;
    for (int k = 0; k < N*N; k++) total += exp_q[k].size();
    return total;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "%s", msg);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Head gets a unique tag in the reserved bits and body flits carry it in the data
  task automatic make_worm(input int i, input int dx, input int dy, input int len);
    header_t h;
    flit_t   f;
    h.preamble.head = 1'b1;
    h.preamble.tail = (len == 1);
    h.source        = xy_t'($urandom);
    h.destination.x = coord_t'(dx);
    h.destination.y = coord_t'(dy);
    h.message       = message_t'($urandom);
    h.reserved      = seq[9:0];
    h.route         = route_t'(1) << toward(POS_X, POS_Y, dx, dy);
    seq++;
    send_q[i].push_back(flit_t'(h));
    for (int k = 1; k < len; k++) begin
      f = {1'b0, k == len - 1, seq[9:0], 22'($urandom)};
      seq++;
      send_q[i].push_back(f);
    end
    worms_made++;
  endtask

  // Random destination that is never this router nor back out the arrival port
  task automatic random_worm(input int i);
    int dx;
    int dy;
    do begin
      dx = $urandom_range(4);
      dy = $urandom_range(4);
    end while ((dx == POS_X && dy == POS_Y) || toward(POS_X, POS_Y, dx, dy) == i);
    make_worm(i, dx, dy, $urandom_range(4, 1));
  endtask

  // Flit goes on the link and into the model with its look-ahead route
  task automatic drive_flit(input int i);
    flit_t   f;
    header_t h;
    f = send_q[i].pop_front();
    h = header_t'(f);
    if (h.preamble.head) begin
      cur_out[i] = port_of(h.route);
      h.route    = next_hop(cur_out[i], h);
    end
    exp_q[i*N + cur_out[i]].push_back(flit_t'(h));
    data_i[i] = f;
    void_i[i] = 1'b0;
  endtask

  // Single head from Local into an idle router
  task automatic check_latency(input int dx, input int dy);
    int      out;
    header_t h;
    @(posedge clk);
    #DRIVE_DELAY;
    out = toward(POS_X, POS_Y, dx, dy);
    make_worm(PORT_LOCAL, dx, dy, 1);
    h       = header_t'(send_q[PORT_LOCAL][0]);
    h.route = next_hop(out, h);
    drive_flit(PORT_LOCAL);
    @(posedge clk);
    #1;
    assert (!void_o[out] && data_o[out] == flit_t'(h))
      else report_error($sformatf("Fail latency: expected %h actual %h", flit_t'(h), data_o[out]));
    #(DRIVE_DELAY - 1);
    void_i = '1;
  endtask

  ////////////////////
  // Scoreboard
  ////////////////////

  task automatic check_flit(input int o, input flit_t f);
    header_t h;
    flit_t   exp;
    int      src;
    h   = header_t'(f);
    src = lock_src[o];
    if (src < 0) begin
      assert (h.preamble.head)
        else report_error($sformatf("Output %0d began a worm without a head flit", o));
      assert (h.route == next_hop(o, h))
        else report_error($sformatf("Fail next_hop: expected %b actual %b",
                                    next_hop(o, h), h.route));
      for (int i = 0; i < N; i++) begin
        if (exp_q[i*N + o].size() > 0 && exp_q[i*N + o][0] == f) src = i;
      end
      assert (src >= 0)
        else report_error($sformatf("Output %0d sent flit %h that no input had pending", o, f));
    end
    assert (exp_q[src*N + o].size() > 0)
      else report_error($sformatf("Output %0d sent an extra flit %h", o, f));
    exp = exp_q[src*N + o].pop_front();
    assert (f == exp)
      else report_error($sformatf("Fail worm_order: expected %h actual %h", exp, f));
    lock_src[o] = h.preamble.tail ? -1 : src;
  endtask

  // Outputs sampled mid cycle away from both edges and the drive point
  always @(negedge clk) begin : monitor
    flit_t f;
    assert (mesh_router_inst.u_assert.fail_count == 0)
      else report_error("A bound assertion on the router outputs failed");
    for (int o = 0; o < N; o++) begin
      f = data_o[o];
      if (!rst) begin
        if (prev_stop[o]) begin
          assert (void_o[o] == prev_void[o])
            else report_error($sformatf("Fail hold_void: expected %b actual %b",
                                        prev_void[o], void_o[o]));
          assert (f === prev_data[o])
            else report_error($sformatf("Fail hold_data: expected %h actual %h", prev_data[o], f));
        end else if (!void_o[o]) begin
          check_flit(o, f);
        end
      end
      prev_stop[o] = stop_i[o];
      prev_void[o] = void_o[o];
      prev_data[o] = f;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      report_error($sformatf("Timeout after %0d cycles with flits still pending", cycles));
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    bit busy;
    void'($urandom(32'ha018dab5));
    position = '{x: coord_t'(POS_X), y: coord_t'(POS_Y)};
    data_i   = '0;
    void_i   = '1;
    stop_i   = '0;
    cycles   = 0;
    seq      = 0;
    worms_made = 0;
    for (int k = 0; k < N; k++) begin
      lock_src[k] = -1;
      cur_out[k]  = 0;
    end
    @(negedge clk);
    while (rst) @(negedge clk);
    assert (void_o == '1 && stop_o == '0)
      else report_error($sformatf(
        "Fail reset: expected void 11111 stop 00000 actual void %b stop %b", void_o, stop_o));

    // One head toward each neighbour
    check_latency(2, 0);
    check_latency(2, 4);
    check_latency(0, 2);
    check_latency(4, 2);

    // Random worms with random stalls
    busy = 1'b1;
    while (worms_made < NUM_WORMS || busy) begin
      @(posedge clk);
      #DRIVE_DELAY;
      busy = 1'b0;
      for (int o = 0; o < N; o++) stop_i[o] = ($urandom_range(3) == 0);
      for (int i = 0; i < N; i++) begin
        if (send_q[i].size() == 0 && worms_made < NUM_WORMS && $urandom_range(2) == 0) begin
          random_worm(i);
        end
        if (!stop_o[i] && send_q[i].size() > 0 && $urandom_range(3) != 0) begin
          drive_flit(i);
        end else begin
          void_i[i] = 1'b1;
        end
        if (send_q[i].size() > 0) busy = 1'b1;
      end
    end

    // Drain with all outputs open
    @(posedge clk);
    #DRIVE_DELAY;
    void_i = '1;
    stop_i = '0;
    while (pending() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    if (mesh_router_inst.u_assert.fail_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      report_error("A bound assertion on the router outputs failed");
    end
  end

endmodule

// ==== bench/router_assert.sv ====
`include "noc_cfg.svh"

module router_assert import noc_flit_pkg::*; (
  input logic                              clk,
  input logic                              rst,
  input logic  [`NOC_PORT_COUNT-1:0]       stop_i,
  input logic  [`NOC_PORT_COUNT-1:0]       void_o,
  input logic  [`NOC_PORT_COUNT-1:0]       stop_o,
  input flit_t [`NOC_PORT_COUNT-1:0]       data_o
);

  localparam int N = `NOC_PORT_COUNT;

  logic [N-1:0] stop_q;
  logic [N-1:0] open_q;
  logic [N-1:0] new_flit;
  logic [N-1:0] is_head;
  logic [N-1:0] is_tail;
  int unsigned  fail_count = 0;

  for (genvar p = 0; p < N; p++) begin : gen_port
    // Fresh flit when void is low and the last edge was not stalled
    assign new_flit[p] = ~void_o[p] & ~stop_q[p];
    assign is_head[p]  = data_o[p][$bits(flit_t)-1];
    assign is_tail[p]  = data_o[p][$bits(flit_t)-2];

    void_hold: assert property (@(posedge clk) disable iff (rst)
      stop_i[p] |=> $stable(void_o[p]))
      else begin
        $error("void_o changed on port %0d while stop_i was high", p);
        fail_count++;
      end

    // No second head inside an open worm
    head_order: assert property (@(posedge clk) disable iff (rst)
      (new_flit[p] && open_q[p]) |-> !is_head[p])
      else begin
        $error("head flit inside an open worm on port %0d", p);
        fail_count++;
      end
  end

  // Open from a head without tail up to the tail
  always_ff @(posedge clk) begin
    if (rst) begin
      stop_q <= '0;
      open_q <= '0;
    end else begin
      stop_q <= stop_i;
      for (int p = 0; p < N; p++) begin
        if (new_flit[p]) begin
          open_q[p] <= is_tail[p] ? 1'b0 : (is_head[p] | open_q[p]);
        end
      end
    end
  end

  stop_after_reset: assert property (@(posedge clk) $fell(rst) |-> stop_o == '0)
    else begin
      $error("stop_o high right after reset");
      fail_count++;
    end

endmodule

bind mesh_router router_assert u_assert (
  .clk,
  .rst,
  .stop_i,
  .void_o,
  .stop_o,
  .data_o
);

// ==== bench/router_clock.sv ====
module router_clock (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD = 50;

  // Free running clock, period of 100
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Synchronous reset held over the first three edges
  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #10 rst_o = 1'b0;
  end

endmodule

// ==== logic/mesh_router.sv ====
`include "noc_cfg.svh"

module mesh_router import noc_flit_pkg::*, noc_port_pkg::*; (
  input  logic                                clk,
  input  logic                                rst,
  input  xy_t                                 position_i,
  input  flit_t [`NOC_PORT_COUNT-1:0]         data_i,
  input  logic  [`NOC_PORT_COUNT-1:0]         void_i,
  output logic  [`NOC_PORT_COUNT-1:0]         stop_o,
  output flit_t [`NOC_PORT_COUNT-1:0]         data_o,
  output logic  [`NOC_PORT_COUNT-1:0]         void_o,
  input  logic  [`NOC_PORT_COUNT-1:0]         stop_i
);

  localparam int unsigned N = `NOC_PORT_COUNT;

  in_req_t [N-1:0]        in_req;
  // Per output, indexed by slot
  in_req_t [N-1:0][N-1:0] out_view;
  logic    [N-1:0][N-1:0] rd_view;
  // Per input, indexed by output
  logic    [N-1:0][N-1:0] rd_mat;

  for (genvar p = 0; p < N; p++) begin : gen_port

    input_port u_input (
      .clk,
      .rst,
      .position_i,
      .flit_i(data_i[p]),
      .void_i(void_i[p]),
      .rd_i  (|rd_mat[p]),
      .stop_o(stop_o[p]),
      .req_o (in_req[p])
    )
    ;

    ////////////////////
    // Slot rotation
    ////////////////////

    // Slot k of output p carries input (p + k) mod N
    // Route keeps only the bit that points at output p
    for (genvar k = 0; k < N; k++) begin : gen_slot
      localparam int unsigned SRC = (p + k) % N;

      assign out_view[p][k] = '{
        head:       in_req[SRC].head,
        valid:      in_req[SRC].valid,
        route:      in_req[SRC].route & route_t'(1 << p),
        next_route: in_req[SRC].next_route
      };
      assign rd_mat[SRC][p] = rd_view[p][k];
    end

    output_port u_output (
      .clk,
      .rst,
      .req_i (out_view[p]),
      .stop_i(stop_i[p]),
      .rd_o  (rd_view[p]),
      .flit_o(data_o[p]),
      .void_o(void_o[p])
    );

  end

endmodule

// ==== logic/output_port.sv ====
`include "noc_cfg.svh"

module output_port import noc_flit_pkg::*, noc_port_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  in_req_t [`NOC_PORT_COUNT-1:0] req_i,
  input  logic                       stop_i,
  output logic [`NOC_PORT_COUNT-1:0] rd_o,
  output flit_t                      flit_o,
  output logic                       void_o
);

  localparam int unsigned N = `NOC_PORT_COUNT;

  out_state_t state_q;
  out_state_t state_d;
  grant_t     arb_req;
  grant_t     grant;
  logic       grant_valid;
  logic [N-1:0] sel;
  logic [N-1:0] saved_sel_q;
  flit_t      xbar_flit;
  route_t     xbar_next;
  logic       xbar_valid;
  header_t    out_hdr;
  flit_t      out_flit;
  logic       fwd;
  logic       head_fwd;
  logic       tail_fwd;
  flit_t      flit_q;
  logic       void_q;

  ////////////////////
  // Arbitration
  ////////////////////

  // Slot 0 is the input of this same port and never competes
  for (genvar k = 1; k < N; k++) begin : gen_req
    assign arb_req[k-1] = |req_i[k].route;
  end

  output_arbiter u_arbiter (
    .clk,
    .rst,
    .req_i        (arb_req),
    .head_fwd_i   (head_fwd),
    .tail_fwd_i   (tail_fwd),
    .grant_o      (grant),
    .grant_valid_o(grant_valid)
  );

  // New grant only between worms, saved slot during the payload
  always_comb begin
    sel = '0;
    if (state_q == PAYLOAD) begin
      sel = saved_sel_q;
    end else if (grant_valid && !stop_i) begin
      sel = {grant, 1'b0};
    end
  end

  ////////////////////
  // Crossbar
  ////////////////////

  always_comb begin
    xbar_flit  = '0;
    xbar_next  = '0;
    xbar_valid = 1'b0;
    for (int k = 0; k < N; k++) begin
      if (sel[k]) begin
        xbar_flit  = req_i[k].head;
        xbar_next  = req_i[k].next_route;
        xbar_valid = req_i[k].valid;
      end
    end
  end

  // First flit of a worm leaves with the look-ahead route
  always_comb begin
    out_hdr = header_t'(xbar_flit);
    if (state_q == HEAD_FLIT) begin
      out_hdr.route = xbar_next;
    end
  end

  assign out_flit = flit_t'(out_hdr);

  ////////////////////
  // Flow control
  ////////////////////

  assign fwd      = ~stop_i & xbar_valid;
  assign head_fwd = fwd & out_hdr.preamble.head;
  assign tail_fwd = fwd & out_hdr.preamble.tail;

  // No FIFO read while downstream stalls
  assign rd_o = stop_i ? '0 : sel;

  always_comb begin
    state_d = state_q;
    case (state_q)
      HEAD_FLIT: begin
        if (head_fwd && !tail_fwd) begin
          state_d = PAYLOAD;
        end
      end
      PAYLOAD: begin
        if (tail_fwd) begin
          state_d = HEAD_FLIT;
        end
      end
      default: begin
        state_d = HEAD_FLIT;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= HEAD_FLIT;
      saved_sel_q <= '0;
      void_q      <= 1'b1;
    end else begin
      state_q <= state_d;
      if (head_fwd) begin
        saved_sel_q <= sel;
      end
      // Void frozen together with the flit under stop
      if (!stop_i) begin
        void_q <= ~fwd;
      end
    end
  end

  // Output register
  always_ff @(posedge clk) begin
    if (fwd) begin
      flit_q <= out_flit;
    end
  end

  assign flit_o = flit_q;
  assign void_o = void_q;

endmodule

// ==== logic/output_arbiter.sv ====
module output_arbiter import noc_port_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  grant_t req_i,
  input  logic   head_fwd_i,
  input  logic   tail_fwd_i,
  output grant_t grant_o,
  output logic   grant_valid_o
);

  localparam int unsigned NUM_REQ = $bits(grant_t);

  // Requester slot
  typedef logic [$clog2(NUM_REQ)-1:0] slot_t;

  slot_t  ptr_q;
  slot_t  winner;
  slot_t  idx;
  logic   found;
  logic   locked_q;
  grant_t locked_grant_q;
  grant_t rr_grant;

  ////////////////////
  // Round robin
  ////////////////////

  // Search starts at the pointer and wraps around
  always_comb begin
    rr_grant = '0;
    winner   = ptr_q;
    idx      = ptr_q;
    found    = 1'b0;
    for (int i = 0; i < NUM_REQ; i++) begin
      idx = ptr_q + slot_t'(i);
      if (!found && req_i[idx]) begin
        rr_grant[idx] = 1'b1;
        winner        = idx;
        found         = 1'b1;
      end
    end
  end

  // Worm in flight keeps its grant
  assign grant_o       = locked_q ? locked_grant_q : rr_grant;
  assign grant_valid_o = locked_q | found;

  ////////////////////
  // Lock and pointer
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q          <= '0;
      locked_q       <= 1'b0;
      locked_grant_q <= '0;
    end else begin
      if (head_fwd_i) begin
        // Winner drops to lowest priority
        ptr_q          <= winner + 1'b1;
        locked_grant_q <= grant_o;
      end
      // Single-flit worm never locks
      if (tail_fwd_i) begin
        locked_q <= 1'b0;
      end else if (head_fwd_i) begin
        locked_q <= 1'b1;
      end
    end
  end

endmodule

// ==== logic/input_port.sv ====
`include "noc_cfg.svh"

module input_port import noc_flit_pkg::*, noc_port_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  xy_t     position_i,
  input  flit_t   flit_i,
  input  logic    void_i,
  input  logic    rd_i,
  output logic    stop_o,
  output in_req_t req_o
);

  localparam int unsigned PTR_W = $clog2(`NOC_QUEUE_DEPTH);
  localparam int unsigned CNT_W = $clog2(`NOC_QUEUE_DEPTH + 1);

  flit_t            mem [`NOC_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             empty;
  logic             full;
  logic             push;
  logic             pop;
  logic             store;
  logic             take;
  flit_t            head_flit;
  header_t          head_hdr;
  logic             head_valid;
  route_t           saved_route;
  route_t           cur_route;
  route_t           hop_route;
  xy_t              next_pos;

  ////////////////////
  // Input FIFO
  ////////////////////

  assign empty = count == '0;
  assign full  = count == CNT_W'(`NOC_QUEUE_DEPTH);

  // Empty FIFO shows the link flit directly
  assign head_flit  = empty ? flit_i : mem[rd_ptr];
  assign head_valid = ~empty | ~void_i;

  assign push = ~void_i & ~full;
  assign pop  = rd_i & head_valid;
  // Bypassed flit never lands in memory
  assign store = push & ~(empty & pop);
  assign take  = pop & ~empty;

  always_ff @(posedge clk) begin
    if (store) begin
      mem[wr_ptr] <= flit_i;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (store) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(store) - CNT_W'(take);
    end
  end

  // Sender stalls while the queue is full
  assign stop_o = full;

  ////////////////////
  // Worm route hold
  ////////////////////

  assign head_hdr = header_t'(head_flit);

  // Route captured when the head leaves, dropped with the tail
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_route <= '0;
    end else if (pop && head_hdr.preamble.tail) begin
      saved_route <= '0;
    end else if (pop && head_hdr.preamble.head) begin
      saved_route <= head_hdr.route;
    end
  end

  // Waiting head requests with its own field, body flits use the held one
  assign cur_route = (head_valid && head_hdr.preamble.head) ? head_hdr.route : saved_route;

  ////////////////////
  // Look-ahead route
  ////////////////////

  // Position of the neighbour this flit goes to
  always_comb begin
    next_pos = position_i;
    if (head_hdr.route[PORT_NORTH]) begin
      next_pos.y = position_i.y - 1'b1;
    end else if (head_hdr.route[PORT_SOUTH]) begin
      next_pos.y = position_i.y + 1'b1;
    end else if (head_hdr.route[PORT_WEST]) begin
      next_pos.x = position_i.x - 1'b1;
    end else if (head_hdr.route[PORT_EAST]) begin
      next_pos.x = position_i.x + 1'b1;
    end
  end

  // XY order seen from that neighbour
  always_comb begin
    if (head_hdr.destination.x < next_pos.x) begin
      hop_route = GO_WEST;
    end else if (head_hdr.destination.x > next_pos.x) begin
      hop_route = GO_EAST;
    end else if (head_hdr.destination.y < next_pos.y) begin
      hop_route = GO_NORTH;
    end else if (head_hdr.destination.y > next_pos.y) begin
      hop_route = GO_SOUTH;
    end else begin
      hop_route = GO_LOCAL;
    end
  end

  assign req_o = '{head: head_flit, valid: head_valid, route: cur_route, next_route: hop_route};

endmodule

// ==== logic/noc_port_pkg.sv ====
`include "noc_cfg.svh"

package noc_port_pkg;
  import noc_flit_pkg::*;

  ////////////////////
  // Port naming
  ////////////////////

  // Index of each port, also the bit position in a route
  typedef enum logic [2:0] {
    PORT_NORTH = 3'd0,
    PORT_SOUTH = 3'd1,
    PORT_WEST  = 3'd2,
    PORT_EAST  = 3'd3,
    PORT_LOCAL = 3'd4
  } port_idx_t;

  // One-hot direction
  typedef logic [`NOC_PORT_COUNT-1:0] route_t;

  localparam route_t GO_NORTH = route_t'(1) << PORT_NORTH;
  localparam route_t GO_SOUTH = route_t'(1) << PORT_SOUTH;
  localparam route_t GO_WEST  = route_t'(1) << PORT_WEST;
  localparam route_t GO_EAST  = route_t'(1) << PORT_EAST;
  localparam route_t GO_LOCAL = route_t'(1) << PORT_LOCAL;

  // One-hot over the inputs other than the output's own port
  typedef logic [`NOC_PORT_COUNT-2:0] grant_t;

  // Output FSM
  typedef enum logic {
    HEAD_FLIT = 1'b0,
    PAYLOAD   = 1'b1
  } out_state_t;

  // What one input offers to every output
  typedef struct packed {
    flit_t  head;
    logic   valid;
    route_t route;
    route_t next_route;
  } in_req_t;

endpackage

// ==== logic/noc_flit_pkg.sv ====
`include "noc_cfg.svh"

package noc_flit_pkg;

  ////////////////////
  // Coordinates
  ////////////////////

  // Single coordinate on the mesh
  typedef logic [`NOC_COORD_WIDTH-1:0] coord_t;

  // Router or endpoint position
  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_t;

  // Message class carried by the head flit
  typedef logic [`NOC_MSG_WIDTH-1:0] message_t;

  ////////////////////
  // Flit format
  ////////////////////

  // Worm framing, both bits set for a single-flit worm
  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  // Raw flit as seen on a link
  typedef logic [`NOC_DATA_WIDTH+$bits(preamble_t)-1:0] flit_t;

  // Head flit view, route field sits in the low bits
  typedef struct packed {
    preamble_t preamble;
    xy_t       source;
    xy_t       destination;
    message_t  message;
    logic [`NOC_DATA_WIDTH-2*$bits(xy_t)-`NOC_MSG_WIDTH-`NOC_PORT_COUNT-1:0] reserved;
    logic [`NOC_PORT_COUNT-1:0] route;
  } header_t;

endpackage

// ==== logic/noc_cfg.svh ====
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

////////////////////
// Flit layout
////////////////////

// Link payload width, the two preamble bits come on top
`define NOC_DATA_WIDTH 32

// One mesh coordinate, x or y
`define NOC_COORD_WIDTH 3

// Message type field in the head flit
`define NOC_MSG_WIDTH 5

////////////////////
// Router geometry
////////////////////

// Entries per input FIFO, kept a power of two
`define NOC_QUEUE_DEPTH 4

// North, South, West, East and Local
`define NOC_PORT_COUNT 5

`endif
